//--- verilog.f
+incdir+rtl
rtl/lsq_pkg.sv
rtl/lsq_rr_arbiter.sv
rtl/lsq_bc_switch.sv
rtl/lsq_entry_array.sv
rtl/lsq_broadcaster.sv
rtl/lsq_bc_top.sv
verification/lsq_bc_checker.sv
verification/lsq_bc_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSQ broadcast testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module lsq_bc_tb \
    -Mdir obj_dir

./obj_dir/Vlsq_bc_tb 2>&1 | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- verification/lsq_bc_tb.sv
// LSQ broadcast path testbench
`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_bc_tb
    import lsq_pkg::*;
();

    // ==============================
    // Run lengths
    // ==============================
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int STIM_CYCLES  = 2000;
    // At least one entry leaves per cycle
    localparam int DRAIN_BOUND  = `LSQ_ENTRY_NUM + 2;
    localparam int SLACK_CYCLES = 8;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STIM_CYCLES + DRAIN_BOUND + SLACK_CYCLES;
    localparam int TAG_NUM      = 1 << `LSQ_TAG_WIDTH;
    // Non-overlapping steady stall window per port
    localparam int STEADY_START = 300;
    localparam int STEADY_GAP   = 700;
    localparam int STEADY_LEN   = 200;

    logic                  clk;
    logic                  rst;
    lsq_fill_t             fill;
    logic [`LOAD_NUM-1:0]  stall;
    logic                  full;
    cdb_t [`LOAD_NUM-1:0]  cdb;

    // Reference model state
    bit                         pend_valid [TAG_NUM];
    logic [`LSQ_DATA_WIDTH-1:0] pend_data  [TAG_NUM];
    int                         pend_cnt;
    int                         occupancy;
    bit                         fill_sent;
    logic [`LOAD_NUM-1:0]       stall_prev;
    logic [`LSQ_TAG_WIDTH-1:0]  next_tag;

    lsq_bc_top lsq_bc_top_i (
        .clk_i   (clk),
        .rst_i   (rst),
        .fill_i  (fill),
        .stall_i (stall),
        .full_o  (full),
        .cdb_o   (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // Failure reporting
    // ==============================
    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // ==============================
    // Model update and output checks
    // ==============================
    // Outputs here reflect the last rising edge
    task automatic check_outputs();
        logic [`LSQ_TAG_WIDTH-1:0] tag;
        if (fill_sent) begin
            occupancy++;
        end
        // Duplicate tags checked before any leave the pending set
        for (int p = 0; p < `LOAD_NUM; p++) begin
            for (int q = p + 1; q < `LOAD_NUM; q++) begin
                if (cdb[p].valid && cdb[q].valid && cdb[p].tag == cdb[q].tag) begin
                    report_failure($sformatf("ports %0d and %0d both carry tag 0x%0h",
                                             p, q, cdb[p].tag));
                end
            end
        end
        for (int p = 0; p < `LOAD_NUM; p++) begin
            // Stall in the previous cycle means an empty slot now
            if (stall_prev[p]) begin
                compare_value($sformatf("cdb_o[%0d].valid", p), 64'(cdb[p].valid), 64'(0));
            end
            if (cdb[p].valid) begin
                tag = cdb[p].tag;
                if (!pend_valid[tag]) begin
                    report_failure($sformatf("port %0d broadcast tag 0x%0h that is not pending",
                                             p, tag));
                end
                compare_value($sformatf("cdb_o[%0d].data", p), 64'(cdb[p].data),
                              64'(pend_data[tag]));
                pend_valid[tag] = 1'b0;
                pend_cnt--;
                occupancy--;
            end
        end
        compare_value("full_o", 64'(full), 64'(occupancy == `LSQ_ENTRY_NUM));
    endtask

    // ==============================
    // Stimulus
    // ==============================
    // Full sampled here holds until the next rising edge
    task automatic drive_inputs(input bit allow_fill, input bit allow_stall, input int cyc);
        logic [`LOAD_NUM-1:0] st;
        int                   win;
        fill_sent = 1'b0;
        fill      = '0;
        // Wait while full and never reuse a pending tag
        if (allow_fill && !full && ($urandom % 100) < 60 && !pend_valid[next_tag]) begin
            fill.valid = 1'b1;
            fill.tag   = next_tag;
            fill.data  = $urandom;
            pend_valid[next_tag] = 1'b1;
            pend_data[next_tag]  = fill.data;
            pend_cnt++;
            next_tag++;
            fill_sent = 1'b1;
        end
        st = '0;
        if (allow_stall) begin
            for (int p = 0; p < `LOAD_NUM; p++) begin
                win = STEADY_START + p * STEADY_GAP;
                if (cyc >= win && cyc < win + STEADY_LEN) begin
                    st[p] = 1'b1;
                end else begin
                    st[p] = (($urandom % 100) < 30);
                end
            end
        end
        stall      = st;
        stall_prev = st;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int drained;
        void'($urandom(89));
        rst        = 1'b1;
        fill       = '0;
        stall      = '0;
        fill_sent  = 1'b0;
        stall_prev = '0;
        next_tag   = '0;
        pend_cnt   = 0;
        occupancy  = 0;
        drained    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Reset state
        compare_value("full_o", 64'(full), 64'(0));
        for (int p = 0; p < `LOAD_NUM; p++) begin
            compare_value($sformatf("cdb_o[%0d].valid", p), 64'(cdb[p].valid), 64'(0));
        end
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            drive_inputs(1'b1, 1'b1, cyc);
            @(negedge clk);
            check_outputs();
        end
        // Drain with fills stopped and stalls released
        while (pend_cnt != 0 && drained < DRAIN_BOUND) begin
            drive_inputs(1'b0, 1'b0, 0);
            @(negedge clk);
            check_outputs();
            drained++;
        end
        if (pend_cnt != 0) begin
            report_failure($sformatf("%0d tags still pending after %0d drain cycles",
                                     pend_cnt, DRAIN_BOUND));
        end else begin
            $display("Test OK");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("watchdog expired before the run finished");
    end

endmodule

`default_nettype wire

//--- verification/lsq_bc_checker.sv
// Broadcast switch and port assertions
`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_bc_checker
    import lsq_pkg::*;
#(
    parameter int C_ENTRY_NUM   = `LSQ_ENTRY_NUM,
    parameter int C_PORT_NUM    = `LOAD_NUM,
    // Switch side when set, port side when clear
    parameter bit C_SWITCH_SIDE = 1'b1
) (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    // Switch side
    input  fu_bc_t [C_ENTRY_NUM-1:0]                 entry_req_i,
    input  logic   [C_PORT_NUM-1:0][C_ENTRY_NUM-1:0] grant_mask_i,
    input  bc_fu_t [C_ENTRY_NUM-1:0]                 entry_ans_i,
    input  bc_fu_t [C_PORT_NUM-1:0]                  port_ans_i,
    // Port side
    input  logic   [C_PORT_NUM-1:0]                  stall_i,
    input  cdb_t   [C_PORT_NUM-1:0]                  cdb_i
);

    // Request bits pulled out of the records
    logic [C_ENTRY_NUM-1:0] req_vec;

    always_comb begin
        for (int unsigned e = 0; e < C_ENTRY_NUM; e++) begin
            req_vec[e] = entry_req_i[e].valid;
        end
    end

    if (C_SWITCH_SIDE) begin : g_switch
        // ==============================
        // Grants and routed answers
        // ==============================
        // Each answering port reaches exactly one entry of its own
        a_ans_count: assert property (@(posedge clk_i) disable iff (rst_i)
            $countones(entry_ans_i) == $countones(port_ans_i))
            else $error("answered entries do not match answering ports");

        for (genvar p = 0; p < C_PORT_NUM; p++) begin : g_port
            // Only requesting entries may be granted
            a_grant_req: assert property (@(posedge clk_i) disable iff (rst_i)
                (grant_mask_i[p] & ~req_vec) == '0)
                else $error("port %0d granted an idle entry", p);
            for (genvar q = p + 1; q < C_PORT_NUM; q++) begin : g_pair
                a_grant_distinct: assert property (@(posedge clk_i) disable iff (rst_i)
                    (grant_mask_i[p] & grant_mask_i[q]) == '0)
                    else $error("ports %0d and %0d granted the same entry", p, q);
            end
        end

        for (genvar e = 0; e < C_ENTRY_NUM; e++) begin : g_entry
            a_ans_req: assert property (@(posedge clk_i) disable iff (rst_i)
                entry_ans_i[e].broadcasted |-> entry_req_i[e].valid)
                else $error("entry %0d answered without a request", e);
        end
    end else begin : g_bus
        // ==============================
        // Stalls and result bus slots
        // ==============================
        for (genvar p = 0; p < C_PORT_NUM; p++) begin : g_port
            // Stalled port leaves its bus slot empty in the next cycle
            a_stall_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
                stall_i[p] |=> !cdb_i[p].valid)
                else $error("stalled port %0d filled its bus slot", p);
        end
    end

endmodule

// Switch records, grant masks and routed answers
bind lsq_bc_switch lsq_bc_checker #(
    .C_ENTRY_NUM   (C_LSQ_ENTRY_NUM),
    .C_PORT_NUM    (C_LOAD_NUM),
    .C_SWITCH_SIDE (1'b1)
) lsq_bc_checker_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .entry_req_i  (lsq_entry_bc_i),
    .grant_mask_i (arb_mask),
    .entry_ans_i  (bc_lsq_entry_o),
    .port_ans_i   (bc_lsq_i),
    .stall_i      ('0),
    .cdb_i        ('0)
);

// Broadcaster stalls and bus slots
bind lsq_broadcaster lsq_bc_checker #(
    .C_PORT_NUM    (C_LOAD_NUM),
    .C_SWITCH_SIDE (1'b0)
) lsq_bc_checker_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .entry_req_i  ('0),
    .grant_mask_i ('0),
    .entry_ans_i  ('0),
    .port_ans_i   ('0),
    .stall_i      (stall_i),
    .cdb_i        (cdb_o)
);

`default_nettype wire

//--- rtl/lsq_bc_top.sv
// LSQ broadcast path top level
`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_bc_top
    import lsq_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Finished load from the pipeline
    input  lsq_fill_t                 fill_i,
    // Per-port result bus hold
    input  logic   [`LOAD_NUM-1:0]    stall_i,
    // No room for another fill
    output logic                      full_o,
    output cdb_t   [`LOAD_NUM-1:0]    cdb_o
);

    // ==============================
    // Internal paths
    // ==============================
    // Entry requests into the switch
    fu_bc_t [`LSQ_ENTRY_NUM-1:0] lsq_entry_bc;
    // Routed requests into the broadcaster
    fu_bc_t [`LOAD_NUM-1:0]      lsq_bc;
    // Port answers back to the switch
    bc_fu_t [`LOAD_NUM-1:0]      bc_lsq;
    // Answers routed to entries
    bc_fu_t [`LSQ_ENTRY_NUM-1:0] bc_lsq_entry;

    lsq_entry_array #(
        .C_LSQ_ENTRY_NUM (`LSQ_ENTRY_NUM)
    ) lsq_entry_array_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fill_i         (fill_i),
        .bc_lsq_entry_i (bc_lsq_entry),
        .lsq_entry_bc_o (lsq_entry_bc),
        .full_o         (full_o)
    );

    lsq_bc_switch #(
        .C_LSQ_ENTRY_NUM (`LSQ_ENTRY_NUM),
        .C_LOAD_NUM      (`LOAD_NUM)
    ) lsq_bc_switch_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lsq_entry_bc_i (lsq_entry_bc),
        .bc_lsq_i       (bc_lsq),
        .lsq_bc_o       (lsq_bc),
        .bc_lsq_entry_o (bc_lsq_entry)
    );

    lsq_broadcaster #(
        .C_LOAD_NUM (`LOAD_NUM)
    ) lsq_broadcaster_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .lsq_bc_i (lsq_bc),
        .bc_lsq_o (bc_lsq),
        .cdb_o    (cdb_o)
    );

endmodule

`default_nettype wire

//--- rtl/lsq_broadcaster.sv
// Result bus broadcaster
`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_broadcaster
    import lsq_pkg::*;
#(
    parameter int C_LOAD_NUM = `LOAD_NUM
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    // External hold, one per port
    input  logic   [C_LOAD_NUM-1:0] stall_i,
    // Routed request per port
    input  fu_bc_t [C_LOAD_NUM-1:0] lsq_bc_i,
    // Same-cycle answer per port
    output bc_fu_t [C_LOAD_NUM-1:0] bc_lsq_o,
    output cdb_t   [C_LOAD_NUM-1:0] cdb_o
);

    // ==============================
    // Stall check
    // ==============================
    logic [C_LOAD_NUM-1:0] bc_take;
    cdb_t [C_LOAD_NUM-1:0] cdb_r;

    // Port takes a valid request unless held
    always_comb begin
        for (int unsigned p = 0; p < C_LOAD_NUM; p++) begin
            bc_take[p]              = lsq_bc_i[p].valid & ~stall_i[p];
            bc_lsq_o[p].broadcasted = bc_take[p];
        end
    end

    // ==============================
    // Result bus register
    // ==============================
    // Slot shows up one cycle after the grant
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cdb_r <= '0;
        end else begin
            for (int unsigned p = 0; p < C_LOAD_NUM; p++) begin
                cdb_r[p].valid <= bc_take[p];
                cdb_r[p].tag   <= lsq_bc_i[p].tag;
                cdb_r[p].data  <= lsq_bc_i[p].data;
            end
        end
    end

    assign cdb_o = cdb_r;

endmodule

`default_nettype wire

//--- rtl/lsq_entry_array.sv
// LSQ entry array
`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_entry_array
    import lsq_pkg::*;
#(
    parameter int C_LSQ_ENTRY_NUM = `LSQ_ENTRY_NUM
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    // Finished load, at most one per cycle
    input  lsq_fill_t                    fill_i,
    // Broadcast answer per entry
    input  bc_fu_t [C_LSQ_ENTRY_NUM-1:0] bc_lsq_entry_i,
    // Broadcast request per entry
    output fu_bc_t [C_LSQ_ENTRY_NUM-1:0] lsq_entry_bc_o,
    output logic                         full_o
);

    // ==============================
    // Local parameters and signals
    // ==============================
    localparam int C_CNT_WIDTH = $clog2(C_LSQ_ENTRY_NUM + 1);

    typedef enum logic {
        ENTRY_FREE  = 1'b0,
        ENTRY_READY = 1'b1
    } entry_state_e;

    entry_state_e [C_LSQ_ENTRY_NUM-1:0] state_r;
    logic [C_LSQ_ENTRY_NUM-1:0][`LSQ_TAG_WIDTH-1:0]  tag_r;
    logic [C_LSQ_ENTRY_NUM-1:0][`LSQ_DATA_WIDTH-1:0] data_r;

    // Fill target, one-hot
    logic [C_LSQ_ENTRY_NUM-1:0] alloc_sel;
    logic [C_LSQ_ENTRY_NUM-1:0] clear_sel;
    logic                       fill_accept;
    logic [C_CNT_WIDTH-1:0]     clear_cnt;
    logic [C_CNT_WIDTH-1:0]     count_r;
    logic [C_CNT_WIDTH-1:0]     count_next;
    logic                       full_r;

    // ==============================
    // Allocation and clear
    // ==============================
    assign fill_accept = fill_i.valid & ~full_r;

    // Lowest-numbered free entry takes the fill
    always_comb begin
        alloc_sel = '0;
        for (int unsigned e = 0; e < C_LSQ_ENTRY_NUM; e++) begin
            if (fill_accept && state_r[e] == ENTRY_FREE && alloc_sel == '0) begin
                alloc_sel[e] = 1'b1;
            end
        end
    end

    // Entries leaving this cycle
    always_comb begin
        clear_cnt = '0;
        for (int unsigned e = 0; e < C_LSQ_ENTRY_NUM; e++) begin
            clear_sel[e] = bc_lsq_entry_i[e].broadcasted & (state_r[e] == ENTRY_READY);
            clear_cnt    = clear_cnt + C_CNT_WIDTH'(clear_sel[e]);
        end
    end

    // ==============================
    // Entry state and payload
    // ==============================
    always_ff @(posedge clk_i) begin
        for (int unsigned e = 0; e < C_LSQ_ENTRY_NUM; e++) begin
            if (rst_i) begin
                state_r[e] <= ENTRY_FREE;
            end else if (alloc_sel[e]) begin
                state_r[e] <= ENTRY_READY;
            end else if (clear_sel[e]) begin
                state_r[e] <= ENTRY_FREE;
            end
            // Payload has no reset
            if (alloc_sel[e]) begin
                tag_r[e]  <= fill_i.tag;
                data_r[e] <= fill_i.data;
            end
        end
    end

    // Ready entries request a port
    always_comb begin
        for (int unsigned e = 0; e < C_LSQ_ENTRY_NUM; e++) begin
            lsq_entry_bc_o[e].valid = (state_r[e] == ENTRY_READY);
            lsq_entry_bc_o[e].tag   = tag_r[e];
            lsq_entry_bc_o[e].data  = data_r[e];
        end
    end

    // ==============================
    // Occupancy and full flag
    // ==============================
    assign count_next = count_r + C_CNT_WIDTH'(fill_accept) - clear_cnt;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_r <= '0;
            full_r  <= 1'b0;
        end else begin
            count_r <= count_next;
            full_r  <= (count_next == C_CNT_WIDTH'(C_LSQ_ENTRY_NUM));
        end
    end

    assign full_o = full_r;

endmodule

`default_nettype wire

//--- rtl/lsq_bc_switch.sv
// Entry to broadcast port switch
`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_bc_switch
    import lsq_pkg::*;
#(
    parameter int C_LSQ_ENTRY_NUM = `LSQ_ENTRY_NUM,
    parameter int C_LOAD_NUM      = `LOAD_NUM
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    // Requests from every entry
    input  fu_bc_t [C_LSQ_ENTRY_NUM-1:0] lsq_entry_bc_i,
    // Answers from every port
    input  bc_fu_t [C_LOAD_NUM-1:0]      bc_lsq_i,
    // Routed request per port
    output fu_bc_t [C_LOAD_NUM-1:0]      lsq_bc_o,
    // Routed answer per entry
    output bc_fu_t [C_LSQ_ENTRY_NUM-1:0] bc_lsq_entry_o
);

    // ==============================
    // Local parameters and signals
    // ==============================
    localparam int C_IDX_WIDTH = $clog2(C_LSQ_ENTRY_NUM);

    // Requests seen by each arbiter after masking
    logic [C_LOAD_NUM-1:0][C_LSQ_ENTRY_NUM-1:0] arb_req;
    // One-hot of each arbiter's own grant
    logic [C_LOAD_NUM-1:0][C_LSQ_ENTRY_NUM-1:0] arb_mask;
    logic [C_LOAD_NUM-1:0]                      arb_ack;
    logic [C_LOAD_NUM-1:0][C_IDX_WIDTH-1:0]     grant_idx;
    logic [C_LOAD_NUM-1:0]                      grant_valid;

    // ==============================
    // Arbiter cascade
    // ==============================
    for (genvar p = 0; p < C_LOAD_NUM; p++) begin : g_port
        // First port sees every valid entry
        if (p == 0) begin : g_first
            always_comb begin
                for (int unsigned e = 0; e < C_LSQ_ENTRY_NUM; e++) begin
                    arb_req[p][e] = lsq_entry_bc_i[e].valid;
                end
            end
        end else begin : g_next
            // Drop whatever the previous port already took
            assign arb_req[p] = arb_req[p-1] & ~arb_mask[p-1];
        end

        // Grant index as one-hot, empty when nothing granted
        assign arb_mask[p] = grant_valid[p]
            ? (C_LSQ_ENTRY_NUM'(1) << grant_idx[p])
            : '0;

        // Priority moves only when the port took the request
        assign arb_ack[p] = bc_lsq_i[p].broadcasted & grant_valid[p];

        lsq_rr_arbiter #(
            .C_REQ_NUM (C_LSQ_ENTRY_NUM)
        ) lsq_rr_arbiter_i (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .req_i   (arb_req[p]),
            .ack_i   (arb_ack[p]),
            .grant_o (grant_idx[p]),
            .valid_o (grant_valid[p])
        );
    end

    // ==============================
    // Request and answer routing
    // ==============================
    // Granted entry goes to its port, answer comes back to the entry
    always_comb begin
        lsq_bc_o       = '0;
        bc_lsq_entry_o = '0;
        for (int unsigned p = 0; p < C_LOAD_NUM; p++) begin
            if (grant_valid[p]) begin
                lsq_bc_o[p]                    = lsq_entry_bc_i[grant_idx[p]];
                bc_lsq_entry_o[grant_idx[p]]   = bc_lsq_i[p];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsq_rr_arbiter.sv
// Work-conserving round-robin arbiter
`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_rr_arbiter #(
    parameter int C_REQ_NUM = `LSQ_ENTRY_NUM
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    // One request bit per entry
    input  logic [C_REQ_NUM-1:0]         req_i,
    // Grant taken, move priority
    input  logic                         ack_i,
    output logic [$clog2(C_REQ_NUM)-1:0] grant_o,
    output logic                         valid_o
);

    // ==============================
    // Local parameters and signals
    // ==============================
    localparam int C_IDX_WIDTH = $clog2(C_REQ_NUM);

    // Entry with highest priority this cycle
    logic [C_IDX_WIDTH-1:0] ptr_r;
    logic [C_IDX_WIDTH-1:0] grant_idx;
    logic                   grant_found;

    // ==============================
    // Grant selection
    // ==============================
    // Scan from pointer upward, wrap past the last entry
    always_comb begin
        grant_idx   = '0;
        grant_found = 1'b0;
        for (int unsigned i = 0; i < C_REQ_NUM; i++) begin
            int unsigned cand;
            cand = int'(ptr_r) + i;
            // Wrap without a modulo
            if (cand >= C_REQ_NUM) begin
                cand = cand - C_REQ_NUM;
            end
            if (!grant_found && req_i[cand]) begin
                grant_found = 1'b1;
                grant_idx   = C_IDX_WIDTH'(cand);
            end
        end
    end

    // Any request gives a grant in the same cycle
    assign grant_o = grant_idx;
    assign valid_o = grant_found;

    // ==============================
    // Priority pointer
    // ==============================
    // Holds without ack, so a stalled grant repeats
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_r <= '0;
        end else if (ack_i && grant_found) begin
            // One past the granted entry
            if (grant_idx == C_IDX_WIDTH'(C_REQ_NUM - 1)) begin
                ptr_r <= '0;
            end else begin
                ptr_r <= grant_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsq_pkg.sv
// LSQ broadcast path types
`default_nettype none

`include "lsq_settings.svh"

package lsq_pkg;

    // ==============================
    // Entry side records
    // ==============================
    // Completed load offered to the entry array
    typedef struct packed {
        logic                          valid;
        logic [`LSQ_TAG_WIDTH-1:0]     tag;
        logic [`LSQ_DATA_WIDTH-1:0]    data;
    } lsq_fill_t;

    // Broadcast request, same record before and after routing
    typedef struct packed {
        logic                          valid;
        logic [`LSQ_TAG_WIDTH-1:0]     tag;
        logic [`LSQ_DATA_WIDTH-1:0]    data;
    } fu_bc_t;

    // Port answer, request taken this cycle
    typedef struct packed {
        logic                          broadcasted;
    } bc_fu_t;

    // ==============================
    // Result bus
    // ==============================
    // One registered slot of the common result bus
    typedef struct packed {
        logic                          valid;
        logic [`LSQ_TAG_WIDTH-1:0]     tag;
        logic [`LSQ_DATA_WIDTH-1:0]    data;
    } cdb_t;

endpackage

`default_nettype wire

//--- rtl/lsq_settings.svh
// LSQ broadcast path settings
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// ==============================
// Queue geometry
// ==============================
// Number of LSQ entries holding finished loads
`define LSQ_ENTRY_NUM   8
// Number of shared broadcast ports on the result bus
`define LOAD_NUM        2

// ==============================
// Payload widths
// ==============================
// Destination register tag
`define LSQ_TAG_WIDTH   6
// Load result data
`define LSQ_DATA_WIDTH  32

`endif
